/* rtl/priv_pkg.sv */
package priv_pkg;

    typedef enum logic [3:0]
    {
        OP_NONE    = 4'd0,
        OP_CSR     = 4'd1,
        OP_CACOP   = 4'd2,
        OP_ERTN    = 4'd3,
        OP_IDLE    = 4'd4,
        OP_TLBSRCH = 4'd5,
        OP_TLBRD   = 4'd6,
        OP_TLBWR   = 4'd7,
        OP_TLBFILL = 4'd8,
        OP_INVTLB  = 4'd9
    } priv_op_e;

    typedef enum logic [3:0]
    {
        S_IDLE         = 4'd0,
        S_CSR          = 4'd1,
        S_CACOP_I_CALL = 4'd2,
        S_CACOP_I_WAIT = 4'd3,
        S_CACOP_D_CALL = 4'd4,
        S_CACOP_D_WAIT = 4'd5,
        S_FINISH       = 4'd6,
        S_ERTN         = 4'd7,
        S_IDLE_WAIT    = 4'd8,
        S_HALT         = 4'd9,
        S_TLB_WAIT     = 4'd10
    } priv_state_e;

    // csr numbers
    localparam logic [13:0] CSR_CRMD  = 14'h000;
    localparam logic [13:0] CSR_PRMD  = 14'h001;
    localparam logic [13:0] CSR_ERA   = 14'h006;
    localparam logic [13:0] CSR_SAVE0 = 14'h030;
    localparam logic [13:0] CSR_SAVE1 = 14'h031;
    localparam logic [13:0] CSR_SAVE2 = 14'h032;
    localparam logic [13:0] CSR_SAVE3 = 14'h033;

    localparam int MODE_BITS = 3;                   // plv + ie

    localparam logic [2:0] CACOP_ICACHE = 3'd0;
    localparam logic [2:0] CACOP_DCACHE = 3'd1;

endpackage

/* rtl/priv_ctrl.sv */
`timescale 1ns/1ps

module priv_ctrl (
    input  logic                clk,
    input  logic                rstn,
    input  logic                en,
    input  priv_pkg::priv_op_e  op,
    input  logic [31:0]         inst,
    input  logic [31:0]         rj_data,
    input  logic [31:0]         rk_data,
    input  logic [31:0]         csr_rdata,
    input  logic                cacop_i_ready,
    input  logic                cacop_d_ready,
    input  logic                cacop_i_done,
    input  logic                cacop_d_done,
    input  logic                i_idle,
    input  logic                d_idle,
    input  logic                tlb_ready,
    output logic [13:0]         csr_addr,
    output logic                csr_ren,
    output logic                csr_wen,
    output logic [31:0]         csr_wdata,
    output logic [1:0]          cacop_type,
    output logic [31:0]         cacop_vaddr,
    output logic                cacop_i_en,
    output logic                cacop_d_en,
    output logic                ertn_en,
    output logic                block_cache,
    output logic                block_clock,
    output logic                tlb_valid,
    output priv_pkg::priv_op_e  tlb_cmd,
    output logic [4:0]          invtlb_op,
    output logic [31:0]         invtlb_asid,
    output logic [31:0]         invtlb_va,
    output logic                done,
    output logic                rd_we_req,
    output logic [31:0]         rd_value,
    output logic                ertn_done
);

    priv_pkg::priv_state_e state;
    priv_pkg::priv_state_e state_nxt;

    logic [13:0] csr_num;
    logic [4:0]  rj;
    logic [31:0] imm_ext;
    logic [31:0] xchg_data;

    assign csr_num     = inst[23:10];
    assign rj          = inst[9:5];
    assign imm_ext     = {{20{inst[21]}}, inst[21:10]};
    assign cacop_type  = inst[4:3];
    assign cacop_vaddr = rj_data + imm_ext;
    assign invtlb_op   = inst[4:0];
    assign invtlb_asid = rj_data;
    assign invtlb_va   = rk_data;
    assign tlb_cmd     = op;                            // core holds op until commit
    assign xchg_data   = (rd_value & ~rj_data) | (rk_data & rj_data);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            state <= priv_pkg::S_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            priv_pkg::S_IDLE:
            begin
                if (en)
                begin
                    case (op)
                        priv_pkg::OP_CSR:   state_nxt = priv_pkg::S_CSR;
                        priv_pkg::OP_CACOP:
                        begin
                            if (inst[2:0] == priv_pkg::CACOP_ICACHE)
                                state_nxt = priv_pkg::S_CACOP_I_CALL;
                            else if (inst[2:0] == priv_pkg::CACOP_DCACHE)
                                state_nxt = priv_pkg::S_CACOP_D_CALL;
                            else
                                state_nxt = priv_pkg::S_FINISH;   // no cache to call
                        end
                        priv_pkg::OP_ERTN:  state_nxt = priv_pkg::S_ERTN;
                        priv_pkg::OP_IDLE:  state_nxt = priv_pkg::S_IDLE_WAIT;
                        priv_pkg::OP_TLBSRCH, priv_pkg::OP_TLBRD, priv_pkg::OP_TLBWR,
                        priv_pkg::OP_TLBFILL, priv_pkg::OP_INVTLB:
                            state_nxt = priv_pkg::S_TLB_WAIT;
                        default:            state_nxt = priv_pkg::S_IDLE;
                    endcase
                end
            end
            priv_pkg::S_CACOP_I_CALL:
            begin
                if (cacop_i_en && cacop_i_ready)
                    state_nxt = priv_pkg::S_CACOP_I_WAIT;
            end
            priv_pkg::S_CACOP_I_WAIT:
            begin
                if (cacop_i_done)
                    state_nxt = priv_pkg::S_IDLE;
            end
            priv_pkg::S_CACOP_D_CALL:
            begin
                if (cacop_d_en && cacop_d_ready)
                    state_nxt = priv_pkg::S_CACOP_D_WAIT;
            end
            priv_pkg::S_CACOP_D_WAIT:
            begin
                if (cacop_d_done)
                    state_nxt = priv_pkg::S_IDLE;
            end
            priv_pkg::S_IDLE_WAIT:
            begin
                if (i_idle && d_idle)
                    state_nxt = priv_pkg::S_HALT;
            end
            priv_pkg::S_TLB_WAIT:
            begin
                if (tlb_ready)
                    state_nxt = priv_pkg::S_IDLE;
            end
            default:    state_nxt = priv_pkg::S_IDLE;  // csr, finish, ertn, halt
        endcase
    end

    always_comb
    begin
        csr_addr    = 14'd0;
        csr_ren     = 1'b0;
        csr_wen     = 1'b0;
        csr_wdata   = 32'd0;
        ertn_en     = 1'b0;
        block_cache = 1'b0;
        block_clock = 1'b0;
        tlb_valid   = 1'b0;
        done        = 1'b0;
        rd_we_req   = 1'b0;
        ertn_done   = 1'b0;
        case (state)
            priv_pkg::S_IDLE:
            begin
                if (en)
                begin
                    case (op)
                        priv_pkg::OP_CSR:
                        begin
                            csr_addr = csr_num;
                            csr_ren  = 1'b1;                // old value for rd
                        end
                        priv_pkg::OP_ERTN:  ertn_en = 1'b1;
                        priv_pkg::OP_IDLE:  block_cache = 1'b1;
                        priv_pkg::OP_TLBSRCH, priv_pkg::OP_TLBRD, priv_pkg::OP_TLBWR,
                        priv_pkg::OP_TLBFILL, priv_pkg::OP_INVTLB:
                            tlb_valid = 1'b1;
                        default:            tlb_valid = 1'b0;
                    endcase
                end
            end
            priv_pkg::S_CSR:
            begin
                csr_addr  = csr_num;
                csr_wen   = |rj;                            // rj == 0 is a plain read
                csr_wdata = (rj == 5'd1) ? rk_data : xchg_data;
                done      = 1'b1;
                rd_we_req = 1'b1;
            end
            priv_pkg::S_CACOP_I_WAIT:   done = cacop_i_done;
            priv_pkg::S_CACOP_D_WAIT:   done = cacop_d_done;
            priv_pkg::S_FINISH:         done = 1'b1;
            priv_pkg::S_ERTN:
            begin
                done      = 1'b1;
                ertn_done = 1'b1;
            end
            priv_pkg::S_IDLE_WAIT:      block_cache = 1'b1;
            priv_pkg::S_HALT:
            begin
                block_cache = 1'b1;
                block_clock = 1'b1;
                done        = 1'b1;
            end
            priv_pkg::S_TLB_WAIT:       done = tlb_ready;
            default:                    done = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (csr_ren)
            rd_value <= csr_rdata;
    end

    // cache enables rise one cycle into CALL, drop on the ready handshake
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            cacop_i_en <= 1'b0;
            cacop_d_en <= 1'b0;
        end
        else
        begin
            cacop_i_en <= (state == priv_pkg::S_CACOP_I_CALL) && !(cacop_i_en && cacop_i_ready);
            cacop_d_en <= (state == priv_pkg::S_CACOP_D_CALL) && !(cacop_d_en && cacop_d_ready);
        end
    end

    a_cacop_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(cacop_i_en && cacop_d_en))
        else $error("both cache maintenance enables high");

    a_wen_done: assert property (@(posedge clk) disable iff (!rstn)
        csr_wen |-> done)
        else $error("csr write without done");

    a_idle_no_done: assert property (@(posedge clk) disable iff (!rstn)
        (state == priv_pkg::S_IDLE) |-> !done)
        else $error("done raised in idle state");

endmodule

/* rtl/csr_regs.sv */
`timescale 1ns/1ps

module csr_regs (
    input  logic        clk,
    input  logic        rstn,
    input  logic [13:0] csr_addr,
    input  logic        csr_ren,
    input  logic        csr_wen,
    input  logic [31:0] csr_wdata,
    input  logic        ertn_en,
    output logic [31:0] csr_rdata,
    output logic [31:0] era,
    output logic [31:0] crmd
);

    logic [priv_pkg::MODE_BITS-1:0] crmd_mode;
    logic [priv_pkg::MODE_BITS-1:0] prmd_mode;
    logic [31:0]                    save_q [4];
    logic                           is_save;

    // save0..3 sit on an aligned block of four
    assign is_save = (csr_addr >= priv_pkg::CSR_SAVE0) && (csr_addr <= priv_pkg::CSR_SAVE3);

    assign crmd = {{(32 - priv_pkg::MODE_BITS){1'b0}}, crmd_mode};

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            crmd_mode <= '0;
            prmd_mode <= '0;
            era       <= 32'd0;
            for (int i = 0; i < 4; i++)
            begin
                save_q[i] <= 32'd0;
            end
        end
        else if (ertn_en)
        begin
            crmd_mode <= prmd_mode;                         // back to saved plv/ie
        end
        else if (csr_wen)
        begin
            case (csr_addr)
                priv_pkg::CSR_CRMD: crmd_mode <= csr_wdata[priv_pkg::MODE_BITS-1:0];
                priv_pkg::CSR_PRMD: prmd_mode <= csr_wdata[priv_pkg::MODE_BITS-1:0];
                priv_pkg::CSR_ERA:  era <= csr_wdata;
                default:
                begin
                    if (is_save)
                        save_q[csr_addr[1:0]] <= csr_wdata;
                end
            endcase
        end
    end

    always_comb
    begin
        csr_rdata = 32'd0;                                  // unknown csr reads 0
        if (csr_ren)
        begin
            case (csr_addr)
                priv_pkg::CSR_CRMD: csr_rdata = crmd;
                priv_pkg::CSR_PRMD: csr_rdata = {{(32 - priv_pkg::MODE_BITS){1'b0}}, prmd_mode};
                priv_pkg::CSR_ERA:  csr_rdata = era;
                default:
                begin
                    if (is_save)
                        csr_rdata = save_q[csr_addr[1:0]];
                end
            endcase
        end
    end

    a_wen_ertn_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(csr_wen && ertn_en))
        else $error("csr write collides with ertn restore");

endmodule

/* rtl/priv_commit.sv */
`timescale 1ns/1ps

module priv_commit (
    input  logic        clk,
    input  logic        rstn,
    input  logic        done,
    input  logic        rd_we_req,
    input  logic [31:0] rd_value,
    input  logic        ertn_done,
    input  logic [31:0] era,
    output logic        commit_valid,
    output logic        rd_we,
    output logic [31:0] rd_wdata,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            commit_valid   <= 1'b0;
            rd_we          <= 1'b0;
            rd_wdata       <= 32'd0;
            redirect_valid <= 1'b0;
            redirect_pc    <= 32'd0;
        end
        else
        begin
            commit_valid   <= done;
            rd_we          <= done && rd_we_req;
            redirect_valid <= done && ertn_done;
            if (done)
            begin
                rd_wdata    <= rd_value;                    // old csr value
                redirect_pc <= era;
            end
        end
    end

    a_commit_kind: assert property (@(posedge clk) disable iff (!rstn)
        !(rd_we && redirect_valid))
        else $error("commit carries both rd write and redirect");

endmodule

/* rtl/priv_exec_top.sv */
`timescale 1ns/1ps

module priv_exec_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                en,
    input  priv_pkg::priv_op_e  op,
    input  logic [31:0]         inst,
    input  logic [31:0]         rj_data,
    input  logic [31:0]         rk_data,
    output logic [1:0]          cacop_type,
    output logic [31:0]         cacop_vaddr,
    output logic                cacop_i_en,
    output logic                cacop_d_en,
    input  logic                cacop_i_ready,
    input  logic                cacop_d_ready,
    input  logic                cacop_i_done,
    input  logic                cacop_d_done,
    input  logic                i_idle,
    input  logic                d_idle,
    output logic                block_cache,
    output logic                block_clock,
    output logic                tlb_valid,
    output priv_pkg::priv_op_e  tlb_cmd,
    input  logic                tlb_ready,
    output logic [4:0]          invtlb_op,
    output logic [31:0]         invtlb_asid,
    output logic [31:0]         invtlb_va,
    output logic [31:0]         crmd,
    output logic                commit_valid,
    output logic                rd_we,
    output logic [31:0]         rd_wdata,
    output logic                redirect_valid,
    output logic [31:0]         redirect_pc
);

    logic [13:0] csr_addr;
    logic        csr_ren;
    logic        csr_wen;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic        ertn_en;
    logic        done;
    logic        rd_we_req;
    logic [31:0] rd_value;
    logic        ertn_done;
    logic [31:0] era;

    priv_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .en            (en),
        .op            (op),
        .inst          (inst),
        .rj_data       (rj_data),
        .rk_data       (rk_data),
        .csr_rdata     (csr_rdata),
        .cacop_i_ready (cacop_i_ready),
        .cacop_d_ready (cacop_d_ready),
        .cacop_i_done  (cacop_i_done),
        .cacop_d_done  (cacop_d_done),
        .i_idle        (i_idle),
        .d_idle        (d_idle),
        .tlb_ready     (tlb_ready),
        .csr_addr      (csr_addr),
        .csr_ren       (csr_ren),
        .csr_wen       (csr_wen),
        .csr_wdata     (csr_wdata),
        .cacop_type    (cacop_type),
        .cacop_vaddr   (cacop_vaddr),
        .cacop_i_en    (cacop_i_en),
        .cacop_d_en    (cacop_d_en),
        .ertn_en       (ertn_en),
        .block_cache   (block_cache),
        .block_clock   (block_clock),
        .tlb_valid     (tlb_valid),
        .tlb_cmd       (tlb_cmd),
        .invtlb_op     (invtlb_op),
        .invtlb_asid   (invtlb_asid),
        .invtlb_va     (invtlb_va),
        .done          (done),
        .rd_we_req     (rd_we_req),
        .rd_value      (rd_value),
        .ertn_done     (ertn_done)
    );

    csr_regs u_csr (
        .clk       (clk),
        .rstn      (rstn),
        .csr_addr  (csr_addr),
        .csr_ren   (csr_ren),
        .csr_wen   (csr_wen),
        .csr_wdata (csr_wdata),
        .ertn_en   (ertn_en),
        .csr_rdata (csr_rdata),
        .era       (era),
        .crmd      (crmd)
    );

    priv_commit u_commit (
        .clk            (clk),
        .rstn           (rstn),
        .done           (done),
        .rd_we_req      (rd_we_req),
        .rd_value       (rd_value),
        .ertn_done      (ertn_done),
        .era            (era),
        .commit_valid   (commit_valid),
        .rd_we          (rd_we),
        .rd_wdata       (rd_wdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* bench/priv_tb.sv */
`timescale 1ns/1ps

module priv_tb;

    typedef enum logic [2:0]
    {
        K_CSR,
        K_ERTN,
        K_CACHE_I,
        K_CACHE_D,
        K_CACHE_X,
        K_IDLE,
        K_TLB
    } kind_e;

    typedef struct packed
    {
        priv_pkg::priv_op_e op;
        logic [31:0]        inst;
        logic [31:0]        rj;
        logic [31:0]        rk;
        kind_e              kind;
    } entry_t;

    logic clk = 1'b0;
    logic rstn;
    logic en;
    priv_pkg::priv_op_e op;
    logic [31:0] inst;
    logic [31:0] rj_data;
    logic [31:0] rk_data;
    logic [1:0]  cacop_type;
    logic [31:0] cacop_vaddr;
    logic        cacop_i_en;
    logic        cacop_d_en;
    logic        cacop_i_ready;
    logic        cacop_d_ready;
    logic        cacop_i_done;
    logic        cacop_d_done;
    logic        i_idle;
    logic        d_idle;
    logic        block_cache;
    logic        block_clock;
    logic        tlb_valid;
    priv_pkg::priv_op_e tlb_cmd;
    logic        tlb_ready;
    logic [4:0]  invtlb_op;
    logic [31:0] invtlb_asid;
    logic [31:0] invtlb_va;
    logic [31:0] crmd;
    logic        commit_valid;
    logic        rd_we;
    logic [31:0] rd_wdata;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    entry_t      table_q [$];
    logic [31:0] model_csr [7];                             // crmd prmd era save0..3
    logic [15:0] lfsr = 16'd98;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          bad_entries = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 100000;

    priv_exec_top uut (
        .clk            (clk),
        .rstn           (rstn),
        .en             (en),
        .op             (op),
        .inst           (inst),
        .rj_data        (rj_data),
        .rk_data        (rk_data),
        .cacop_type     (cacop_type),
        .cacop_vaddr    (cacop_vaddr),
        .cacop_i_en     (cacop_i_en),
        .cacop_d_en     (cacop_d_en),
        .cacop_i_ready  (cacop_i_ready),
        .cacop_d_ready  (cacop_d_ready),
        .cacop_i_done   (cacop_i_done),
        .cacop_d_done   (cacop_d_done),
        .i_idle         (i_idle),
        .d_idle         (d_idle),
        .block_cache    (block_cache),
        .block_clock    (block_clock),
        .tlb_valid      (tlb_valid),
        .tlb_cmd        (tlb_cmd),
        .tlb_ready      (tlb_ready),
        .invtlb_op      (invtlb_op),
        .invtlb_asid    (invtlb_asid),
        .invtlb_va      (invtlb_va),
        .crmd           (crmd),
        .commit_valid   (commit_valid),
        .rd_we          (rd_we),
        .rd_wdata       (rd_wdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("timeout, no progress within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr);
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic logic [13:0] csr_at(input int k);
        case (k)
            0:       return priv_pkg::CSR_CRMD;
            1:       return priv_pkg::CSR_PRMD;
            2:       return priv_pkg::CSR_ERA;
            3:       return priv_pkg::CSR_SAVE0;
            4:       return priv_pkg::CSR_SAVE1;
            5:       return priv_pkg::CSR_SAVE2;
            default: return priv_pkg::CSR_SAVE3;
        endcase
    endfunction

    function automatic int csr_slot(input logic [13:0] a);
        int s;
        s = -1;
        for (int k = 0; k < 7; k++)
        begin
            if (csr_at(k) == a)
                s = k;
        end
        return s;
    endfunction

    function automatic logic [31:0] csr_inst(input logic [13:0] a, input logic [4:0] rj_f);
        return {8'h04, a, rj_f, 5'd4};
    endfunction

    function automatic logic [31:0] cacop_inst(input logic [11:0] imm, input logic [1:0] typ,
                                               input logic [2:0] tgt);
        return {10'h018, imm, 5'd7, typ, tgt};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_entry(input priv_pkg::priv_op_e o, input logic [31:0] i_w,
                             input logic [31:0] rj_v, input logic [31:0] rk_v, input kind_e k);
        entry_t e;
        e.op = o;
        e.inst = i_w;
        e.rj = rj_v;
        e.rk = rk_v;
        e.kind = k;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] val;
        for (int k = 0; k < 7; k++)
            add_entry(priv_pkg::OP_CSR, csr_inst(csr_at(k), 5'd0), 32'd0, 32'd0, K_CSR);
        for (int k = 0; k < 7; k++)
        begin
            val = 32'h5a5a_0003 + 32'(k) * 32'h0011_1111;
            add_entry(priv_pkg::OP_CSR, csr_inst(csr_at(k), 5'd1), 32'd0, val, K_CSR);
            add_entry(priv_pkg::OP_CSR, csr_inst(csr_at(k), 5'd0), 32'd0, 32'd0, K_CSR);
            add_entry(priv_pkg::OP_CSR, csr_inst(csr_at(k), 5'(2 + k)), 32'h0ff0_0f06,
                      ~val, K_CSR);                         // masked exchange
            add_entry(priv_pkg::OP_CSR, csr_inst(csr_at(k), 5'd0), 32'd0, 32'd0, K_CSR);
        end
        add_entry(priv_pkg::OP_CSR, csr_inst(priv_pkg::CSR_PRMD, 5'd1), 0, 32'hffff_fff5, K_CSR);
        add_entry(priv_pkg::OP_CSR, csr_inst(priv_pkg::CSR_ERA, 5'd1), 0, 32'h1c00_1234, K_CSR);
        add_entry(priv_pkg::OP_ERTN, 32'h0648_3800, 0, 0, K_ERTN);
        add_entry(priv_pkg::OP_CSR, csr_inst(priv_pkg::CSR_CRMD, 5'd0), 0, 0, K_CSR);
        add_entry(priv_pkg::OP_CSR, csr_inst(priv_pkg::CSR_PRMD, 5'd1), 0, 32'd2, K_CSR);
        add_entry(priv_pkg::OP_CSR, csr_inst(priv_pkg::CSR_ERA, 5'd1), 0, 32'h8000_0ffc, K_CSR);
        add_entry(priv_pkg::OP_ERTN, 32'h0648_3800, 0, 0, K_ERTN);
        add_entry(priv_pkg::OP_CACOP, cacop_inst(12'hff8, 2'd2, priv_pkg::CACOP_ICACHE),
                  32'h1000_0040, 0, K_CACHE_I);
        add_entry(priv_pkg::OP_CACOP, cacop_inst(12'h123, 2'd1, priv_pkg::CACOP_DCACHE),
                  32'h8000_0000, 0, K_CACHE_D);
        add_entry(priv_pkg::OP_CACOP, cacop_inst(12'h7ff, 2'd0, 3'd2), 32'h0000_1000, 0, K_CACHE_X);
        add_entry(priv_pkg::OP_CACOP, cacop_inst(12'h800, 2'd3, priv_pkg::CACOP_ICACHE),
                  32'h0000_0800, 0, K_CACHE_I);
        add_entry(priv_pkg::OP_IDLE, 32'h0648_8000, 0, 0, K_IDLE);
        add_entry(priv_pkg::OP_IDLE, 32'h0648_8000, 0, 0, K_IDLE);
        add_entry(priv_pkg::OP_TLBSRCH, 32'h0648_2800, 0, 0, K_TLB);
        add_entry(priv_pkg::OP_TLBRD, 32'h0648_2c00, 0, 0, K_TLB);
        add_entry(priv_pkg::OP_TLBWR, 32'h0648_3000, 0, 0, K_TLB);
        add_entry(priv_pkg::OP_TLBFILL, 32'h0648_3400, 0, 0, K_TLB);
        add_entry(priv_pkg::OP_INVTLB, 32'h0649_8005, 32'h0000_003a, 32'h0040_2000, K_TLB);
        add_entry(priv_pkg::OP_INVTLB, 32'h0649_8002, 32'h0000_0011, 32'hbfc0_0000, K_TLB);
    endtask

    task automatic run_entry(input entry_t e, input int idx);
        int          cyc;
        int          tlb_pulses;
        int          clk_pulses;
        int          en_cycles;
        int          mark;                                  // cache done, tlb ready or both idle
        int          slot;
        int          errs_before;
        logic [4:0]  rj_f;
        logic [31:0] old_val;
        logic [31:0] new_val;
        logic [31:0] exp_va;
        errs_before = err_cnt;
        cyc = 0;
        tlb_pulses = 0;
        clk_pulses = 0;
        en_cycles = 0;
        mark = -1;
        rj_f = e.inst[9:5];
        slot = csr_slot(e.inst[23:10]);
        old_val = (slot >= 0) ? model_csr[slot] : 32'd0;
        exp_va = e.rj + {{20{e.inst[21]}}, e.inst[21:10]};
        @(posedge clk);
        #1;
        en = 1'b1;
        op = e.op;
        inst = e.inst;
        rj_data = e.rj;
        rk_data = e.rk;
        #4;
        while (!commit_valid)
        begin
            if (tlb_valid)
            begin
                tlb_pulses++;
                check_value("tlb_valid cycle", cyc, 0);
                check_value("tlb_cmd", 32'(tlb_cmd), 32'(e.op));
                check_value("invtlb_op", 32'(invtlb_op), 32'(e.inst[4:0]));
                check_value("invtlb_asid", invtlb_asid, e.rj);
                check_value("invtlb_va", invtlb_va, e.rk);
            end
            if (cacop_i_en || cacop_d_en)
            begin
                en_cycles++;
                check_value("cacop_i_en", 32'(cacop_i_en), 32'(e.kind == K_CACHE_I));
                check_value("cacop_d_en", 32'(cacop_d_en), 32'(e.kind == K_CACHE_D));
                check_value("cacop_vaddr", cacop_vaddr, exp_va);
                check_value("cacop_type", 32'(cacop_type), 32'(e.inst[4:3]));
            end
            if ((cacop_i_done || cacop_d_done || tlb_ready) && mark < 0)
                mark = cyc;
            if (e.kind == K_IDLE)
            begin
                if (mark < 0)
                    check_value("block_cache", 32'(block_cache), 1);
                if (i_idle && d_idle && mark < 0)
                    mark = cyc;
                if (block_clock)
                begin
                    clk_pulses++;
                    check_value("block_cache at halt", 32'(block_cache), 1);
                    check_value("halt cycle", cyc, mark + 1);
                end
            end
            else
                check_value("block_clock", 32'(block_clock), 0);
            @(posedge clk);
            #1;
            en = 1'b0;
            cyc++;
            #4;
        end
        check_value("tlb_valid pulses", tlb_pulses, 32'(e.kind == K_TLB));
        check_value("cacop enable seen", 32'(en_cycles > 0),
                    32'(e.kind == K_CACHE_I || e.kind == K_CACHE_D));
        check_value("rd_we", 32'(rd_we), 32'(e.kind == K_CSR));
        check_value("redirect_valid", 32'(redirect_valid), 32'(e.kind == K_ERTN));
        case (e.kind)
            K_CSR:
            begin
                check_value("commit cycle", cyc, 2);
                check_value("rd_wdata", rd_wdata, old_val);
                if (rj_f == 5'd1)
                    new_val = e.rk;
                else if (rj_f >= 5'd2)
                    new_val = (old_val & ~e.rj) | (e.rk & e.rj);
                else
                    new_val = old_val;
                if (slot <= 1)
                    new_val = new_val & ((32'd1 << priv_pkg::MODE_BITS) - 32'd1);
                if (slot >= 0)
                    model_csr[slot] = new_val;
            end
            K_ERTN:
            begin
                check_value("commit cycle", cyc, 2);
                check_value("redirect_pc", redirect_pc, model_csr[2]);
                model_csr[0] = model_csr[1];                // mode back from prmd
            end
            K_CACHE_X:  check_value("commit cycle", cyc, 2);
            K_IDLE:
            begin
                check_value("block_clock pulses", clk_pulses, 1);
                check_value("commit cycle", cyc, mark + 2);
            end
            default:    check_value("commit cycle", cyc, mark + 1);
        endcase
        check_value("crmd", crmd, model_csr[0]);
        if (err_cnt != errs_before)
            bad_entries++;
        $display("entry %0d kind %0d op %0d: %s after %0d cycles", idx, e.kind, e.op,
                 (err_cnt == errs_before) ? "ok" : "mismatch", cyc);
    endtask

    // cache responder, ready then done
    initial
    begin
        int   d;
        logic use_d;
        cacop_i_ready = 1'b0;
        cacop_d_ready = 1'b0;
        cacop_i_done = 1'b0;
        cacop_d_done = 1'b0;
        forever
        begin
            @(posedge clk);
            #5;
            if (cacop_i_en || cacop_d_en)
            begin
                use_d = cacop_d_en;
                d = take_bits(3);
                repeat (d) @(posedge clk);
                @(posedge clk);
                #1;
                cacop_i_ready = !use_d;
                cacop_d_ready = use_d;
                @(posedge clk);
                #1;
                cacop_i_ready = 1'b0;
                cacop_d_ready = 1'b0;
                d = take_bits(3);
                repeat (d) @(posedge clk);
                @(posedge clk);
                #1;
                cacop_i_done = !use_d;
                cacop_d_done = use_d;
                @(posedge clk);
                #1;
                cacop_i_done = 1'b0;
                cacop_d_done = 1'b0;
            end
        end
    end

    initial
    begin
        int d;
        tlb_ready = 1'b0;
        forever
        begin
            @(posedge clk);
            #5;
            if (tlb_valid)
            begin
                d = take_bits(3);
                repeat (d) @(posedge clk);
                @(posedge clk);
                #1;
                tlb_ready = 1'b1;
                @(posedge clk);
                #1;
                tlb_ready = 1'b0;
            end
        end
    end

    // caches drain independently, idle held until the halt cycle
    initial
    begin
        int di;
        int dd;
        int k;
        i_idle = 1'b0;
        d_idle = 1'b0;
        forever
        begin
            @(posedge clk);
            #5;
            if (block_cache && !block_clock)
            begin
                di = take_bits(3);
                dd = take_bits(3);
                k = 0;
                while (!(i_idle && d_idle))
                begin
                    @(posedge clk);
                    #1;
                    if (k >= di)
                        i_idle = 1'b1;
                    if (k >= dd)
                        d_idle = 1'b1;
                    k++;
                end
                while (!block_clock)
                begin
                    @(posedge clk);
                    #5;
                end
                @(posedge clk);
                #1;
                i_idle = 1'b0;
                d_idle = 1'b0;
            end
        end
    end

    initial
    begin
        rstn = 1'b0;
        en = 1'b0;
        op = priv_pkg::OP_NONE;
        inst = 32'd0;
        rj_data = 32'd0;
        rk_data = 32'd0;
        for (int k = 0; k < 7; k++)
            model_csr[k] = 32'd0;
        build_table();
        cycle_limit = 40 * table_q.size() + 100;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;
        #4;
        check_value("commit_valid", 32'(commit_valid), 0);
        check_value("rd_we", 32'(rd_we), 0);
        check_value("redirect_valid", 32'(redirect_valid), 0);
        check_value("block_cache", 32'(block_cache), 0);
        check_value("block_clock", 32'(block_clock), 0);
        check_value("cacop_i_en", 32'(cacop_i_en), 0);
        check_value("cacop_d_en", 32'(cacop_d_en), 0);
        check_value("tlb_valid", 32'(tlb_valid), 0);
        check_value("crmd", crmd, 0);
        for (int n = 0; n < table_q.size(); n++)
            run_entry(table_q[n], n);
        @(posedge clk);
        $display("%0d of %0d entries clean, %0d checks, %0d mismatches",
                 table_q.size() - bad_entries, table_q.size(), check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* verilog.f */
rtl/priv_pkg.sv
rtl/priv_ctrl.sv
rtl/csr_regs.sv
rtl/priv_commit.sv
rtl/priv_exec_top.sv
bench/priv_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module priv_tb -o priv_tb_sim

./obj_dir/priv_tb_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
